// ==== source/lsu_replay_pkg.sv ====
// LSU replay package
// Widths, hazard type enum, hazard info union, branch flush helper

package lsu_replay_pkg;

    localparam int PADDR_W       = 32;
    localparam int CMT_ID_W      = 6;
    localparam int BR_MASK_W     = 4;   // One bit per in-flight branch tag
    localparam int MISSU_ENTRIES = 8;

    typedef enum logic [1:0] {
        HAZ_L1D_CONFLICT   = 2'd0,
        HAZ_MISSU_FULL     = 2'd1,
        HAZ_MISSU_ASSIGNED = 2'd2,
        HAZ_STQ_NONFWD     = 2'd3
    } haz_typ_t;

    // Same word, read according to the hazard type
    typedef union packed {
        logic [MISSU_ENTRIES-1:0] missu_index_oh;   // HAZ_MISSU_ASSIGNED
        logic [MISSU_ENTRIES-1:0] stq_id;           // HAZ_STQ_NONFWD
    } haz_info_u;

    function automatic logic is_br_flush_target(
        input logic [BR_MASK_W-1:0] br_mask,
        input logic [BR_MASK_W-1:0] br_tag,
        input logic                 mispredict
    );
        return (|(br_mask & br_tag)) & mispredict;
    endfunction

endpackage

// ==== source/ring_fifo.sv ====
// Circular FIFO of packed words
// Oldest word is visible on o_data without a pop

`timescale 1ns/10ps

module ring_fifo #(
    parameter int WIDTH       = 32,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [WIDTH-1:0] r_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] r_head;
    logic [PTR_W-1:0] r_tail;
    logic [CNT_W-1:0] r_count;
    logic             w_push;
    logic             w_pop;

    assign o_empty = (r_count == '0);
    assign o_full  = (r_count == CNT_W'(QUEUE_DEPTH));
    assign w_push  = i_push & ~o_full;
    assign w_pop   = i_pop & ~o_empty;
    assign o_data  = r_mem[r_head];

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_head  <= '0;
            r_tail  <= '0;
            r_count <= '0;
        end else begin
            if (w_push) begin
                r_tail <= (r_tail == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_tail + 1'b1;
            end
            if (w_pop) begin
                r_head <= (r_head == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_head + 1'b1;
            end
            r_count <= r_count + CNT_W'(w_push) - CNT_W'(w_pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_mem[r_tail] <= i_data;
        end
    end

endmodule

// ==== source/lsu_replay_queue.sv ====
// Replay queue for one LSU pipe
// Payload FIFO plus per-slot dead/br_mask, head wakeup, credit return

`timescale 1ns/10ps

module lsu_replay_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset_n,
    input  logic                                    i_haz_valid,
    input  logic [lsu_replay_pkg::PADDR_W-1:0]      i_haz_paddr,
    input  logic [lsu_replay_pkg::CMT_ID_W-1:0]     i_haz_cmt_id,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0]    i_haz_br_mask,
    input  lsu_replay_pkg::haz_typ_t                i_haz_haz_typ,
    input  lsu_replay_pkg::haz_info_u               i_haz_haz_info,
    input  logic                                    i_missu_full,
    input  logic                                    i_missu_resolve_valid,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_missu_resolve_oh,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_missu_entry_valids,
    input  logic                                    i_stq_resolve_valid,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_stq_resolve_id,
    input  logic                                    i_br_update,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0]    i_br_tag,
    input  logic                                    i_br_mispredict,
    output logic                                    o_req_valid,
    output logic [lsu_replay_pkg::PADDR_W-1:0]      o_req_paddr,
    output logic [lsu_replay_pkg::CMT_ID_W-1:0]     o_req_cmt_id,
    output logic [lsu_replay_pkg::BR_MASK_W-1:0]    o_req_br_mask,
    output lsu_replay_pkg::haz_typ_t                o_req_haz_typ,
    output lsu_replay_pkg::haz_info_u               o_req_haz_info,
    input  logic                                    i_req_ready,
    output logic                                    o_credit
);
    import lsu_replay_pkg::*;

    // FIFO word is {paddr, cmt_id, haz_typ, haz_info}
    localparam int TYP_LSB  = MISSU_ENTRIES;
    localparam int CMT_LSB  = TYP_LSB + $bits(haz_typ_t);
    localparam int ADDR_LSB = CMT_LSB + CMT_ID_W;
    localparam int WIDTH    = ADDR_LSB + PADDR_W;
    localparam int PTR_W    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [WIDTH-1:0]     w_wr_data;
    logic [WIDTH-1:0]     w_rd_data;
    logic                 w_empty;
    logic                 w_full;
    logic                 w_push;
    logic                 w_pop;
    logic                 w_wake;
    logic                 w_head_dead;
    logic [PTR_W-1:0]     r_wr_ptr;
    logic [PTR_W-1:0]     r_rd_ptr;
    logic [QUEUE_DEPTH-1:0] r_slot_valid;
    logic [QUEUE_DEPTH-1:0] r_slot_dead;
    logic [QUEUE_DEPTH-1:0] w_flush;
    logic [BR_MASK_W-1:0] r_slot_br_mask [QUEUE_DEPTH];
    logic                 r_credit;

    assign w_push    = i_haz_valid & ~w_full;
    assign w_wr_data = {i_haz_paddr, i_haz_cmt_id, i_haz_haz_typ, i_haz_haz_info};

    ring_fifo #(
        .WIDTH       (WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_push),
        .i_data    (w_wr_data),
        .i_pop     (w_pop),
        .o_data    (w_rd_data),
        .o_empty   (w_empty),
        .o_full    (w_full)
    );

    assign o_req_paddr    = w_rd_data[ADDR_LSB +: PADDR_W];
    assign o_req_cmt_id   = w_rd_data[CMT_LSB +: CMT_ID_W];
    assign o_req_haz_typ  = haz_typ_t'(w_rd_data[TYP_LSB +: $bits(haz_typ_t)]);
    assign o_req_haz_info = w_rd_data[MISSU_ENTRIES-1:0];
    assign o_req_br_mask  = r_slot_br_mask[r_rd_ptr];

    // ------------------------------
    // Slot side state
    // ------------------------------
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            w_flush[i] = i_br_update &
                         is_br_flush_target(r_slot_br_mask[i], i_br_tag, i_br_mispredict);
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_wr_ptr     <= '0;
            r_rd_ptr     <= '0;
            r_slot_valid <= '0;
            r_slot_dead  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (w_push && r_wr_ptr == PTR_W'(i)) begin
                    r_slot_valid[i] <= 1'b1;
                    r_slot_dead[i]  <= 1'b0;      // New entry never flushed on arrival
                end else if (w_pop && r_rd_ptr == PTR_W'(i)) begin
                    r_slot_valid[i] <= 1'b0;
                end else if (r_slot_valid[i] && w_flush[i]) begin
                    r_slot_dead[i]  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_slot_br_mask[r_wr_ptr] <= i_haz_br_mask;
        end
    end

    // ------------------------------
    // Head wakeup and pop
    // ------------------------------
    always_comb begin
        case (o_req_haz_typ)
            HAZ_L1D_CONFLICT:   w_wake = 1'b1;
            HAZ_MISSU_FULL:     w_wake = ~i_missu_full;
            HAZ_MISSU_ASSIGNED: begin
                w_wake = (i_missu_resolve_valid &
                          (i_missu_resolve_oh == o_req_haz_info.missu_index_oh)) |
                         ((o_req_haz_info.missu_index_oh & i_missu_entry_valids) == '0);
            end
            HAZ_STQ_NONFWD: begin
                w_wake = i_stq_resolve_valid & (i_stq_resolve_id == o_req_haz_info.stq_id);
            end
            default:            w_wake = 1'b0;
        endcase
    end

    assign w_head_dead = ~w_empty & r_slot_dead[r_rd_ptr];
    assign o_req_valid = ~w_empty & ~r_slot_dead[r_rd_ptr] & w_wake;
    assign w_pop       = (o_req_valid & i_req_ready) | w_head_dead;  // Dead head drains silently

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_credit <= 1'b0;
        end else begin
            r_credit <= w_pop;
        end
    end

    assign o_credit = r_credit;

endmodule

// ==== source/lsu_replay_arbiter.sv ====
// Round-robin merge of two replay queues onto the issue port

`timescale 1ns/10ps

module lsu_replay_arbiter (
    input  logic                                 i_clk,
    input  logic                                 i_reset_n,
    input  logic                                 i_req0_valid,
    input  logic [lsu_replay_pkg::PADDR_W-1:0]   i_req0_paddr,
    input  logic [lsu_replay_pkg::CMT_ID_W-1:0]  i_req0_cmt_id,
    input  lsu_replay_pkg::haz_typ_t             i_req0_haz_typ,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0] i_req0_br_mask,
    output logic                                 o_req0_ready,
    input  logic                                 i_req1_valid,
    input  logic [lsu_replay_pkg::PADDR_W-1:0]   i_req1_paddr,
    input  logic [lsu_replay_pkg::CMT_ID_W-1:0]  i_req1_cmt_id,
    input  lsu_replay_pkg::haz_typ_t             i_req1_haz_typ,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0] i_req1_br_mask,
    output logic                                 o_req1_ready,
    output logic                                 o_rep_valid,
    output logic                                 o_rep_pipe,
    output logic [lsu_replay_pkg::PADDR_W-1:0]   o_rep_paddr,
    output logic [lsu_replay_pkg::CMT_ID_W-1:0]  o_rep_cmt_id,
    output lsu_replay_pkg::haz_typ_t             o_rep_haz_typ,
    output logic [lsu_replay_pkg::BR_MASK_W-1:0] o_rep_br_mask,
    input  logic                                 i_rep_ready
);

    logic r_rr_ptr;     // Side favoured when both request
    logic w_grant1;

    assign w_grant1 = i_req1_valid & (~i_req0_valid | r_rr_ptr);

    assign o_rep_valid   = i_req0_valid | i_req1_valid;
    assign o_rep_pipe    = w_grant1;
    assign o_rep_paddr   = w_grant1 ? i_req1_paddr   : i_req0_paddr;
    assign o_rep_cmt_id  = w_grant1 ? i_req1_cmt_id  : i_req0_cmt_id;
    assign o_rep_haz_typ = w_grant1 ? i_req1_haz_typ : i_req0_haz_typ;
    assign o_rep_br_mask = w_grant1 ? i_req1_br_mask : i_req0_br_mask;

    assign o_req0_ready = i_rep_ready & ~w_grant1;
    assign o_req1_ready = i_rep_ready & w_grant1;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_rr_ptr <= 1'b0;
        end else if (o_rep_valid && i_rep_ready) begin
            r_rr_ptr <= ~w_grant1;  // Point at the side not just served
        end
    end

endmodule

// ==== source/lsu_replay_top.sv ====
// LSU replay subsystem top
// Two per-pipe replay queues feeding one arbiter

`timescale 1ns/10ps

module lsu_replay_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_reset_n,
    input  logic                                    i_haz0_valid,
    input  logic [lsu_replay_pkg::PADDR_W-1:0]      i_haz0_paddr,
    input  logic [lsu_replay_pkg::CMT_ID_W-1:0]     i_haz0_cmt_id,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0]    i_haz0_br_mask,
    input  lsu_replay_pkg::haz_typ_t                i_haz0_haz_typ,
    input  lsu_replay_pkg::haz_info_u               i_haz0_haz_info,
    input  logic                                    i_haz1_valid,
    input  logic [lsu_replay_pkg::PADDR_W-1:0]      i_haz1_paddr,
    input  logic [lsu_replay_pkg::CMT_ID_W-1:0]     i_haz1_cmt_id,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0]    i_haz1_br_mask,
    input  lsu_replay_pkg::haz_typ_t                i_haz1_haz_typ,
    input  lsu_replay_pkg::haz_info_u               i_haz1_haz_info,
    input  logic                                    i_missu_full,
    input  logic                                    i_missu_resolve_valid,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_missu_resolve_oh,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_missu_entry_valids,
    input  logic                                    i_stq_resolve_valid,
    input  logic [lsu_replay_pkg::MISSU_ENTRIES-1:0] i_stq_resolve_id,
    input  logic                                    i_br_update,
    input  logic [lsu_replay_pkg::BR_MASK_W-1:0]    i_br_tag,
    input  logic                                    i_br_mispredict,
    output logic                                    o_credit0,
    output logic                                    o_credit1,
    output logic                                    o_rep_valid,
    output logic                                    o_rep_pipe,
    output logic [lsu_replay_pkg::PADDR_W-1:0]      o_rep_paddr,
    output logic [lsu_replay_pkg::CMT_ID_W-1:0]     o_rep_cmt_id,
    output lsu_replay_pkg::haz_typ_t                o_rep_haz_typ,
    output logic [lsu_replay_pkg::BR_MASK_W-1:0]    o_rep_br_mask,
    input  logic                                    i_rep_ready
);
    import lsu_replay_pkg::*;

    logic                 w_req0_valid;
    logic                 w_req0_ready;
    logic [PADDR_W-1:0]   w_req0_paddr;
    logic [CMT_ID_W-1:0]  w_req0_cmt_id;
    logic [BR_MASK_W-1:0] w_req0_br_mask;
    haz_typ_t             w_req0_haz_typ;
    logic                 w_req1_valid;
    logic                 w_req1_ready;
    logic [PADDR_W-1:0]   w_req1_paddr;
    logic [CMT_ID_W-1:0]  w_req1_cmt_id;
    logic [BR_MASK_W-1:0] w_req1_br_mask;
    haz_typ_t             w_req1_haz_typ;

    // ------------------------------
    // Per-pipe queues
    // ------------------------------
    lsu_replay_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue0 (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_haz_valid           (i_haz0_valid),
        .i_haz_paddr           (i_haz0_paddr),
        .i_haz_cmt_id          (i_haz0_cmt_id),
        .i_haz_br_mask         (i_haz0_br_mask),
        .i_haz_haz_typ         (i_haz0_haz_typ),
        .i_haz_haz_info        (i_haz0_haz_info),
        .i_missu_full          (i_missu_full),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_oh    (i_missu_resolve_oh),
        .i_missu_entry_valids  (i_missu_entry_valids),
        .i_stq_resolve_valid   (i_stq_resolve_valid),
        .i_stq_resolve_id      (i_stq_resolve_id),
        .i_br_update           (i_br_update),
        .i_br_tag              (i_br_tag),
        .i_br_mispredict       (i_br_mispredict),
        .o_req_valid           (w_req0_valid),
        .o_req_paddr           (w_req0_paddr),
        .o_req_cmt_id          (w_req0_cmt_id),
        .o_req_br_mask         (w_req0_br_mask),
        .o_req_haz_typ         (w_req0_haz_typ),
        .o_req_haz_info        (),          // Wakeup use only, not issued
        .i_req_ready           (w_req0_ready),
        .o_credit              (o_credit0)
    );

    lsu_replay_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue1 (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_haz_valid           (i_haz1_valid),
        .i_haz_paddr           (i_haz1_paddr),
        .i_haz_cmt_id          (i_haz1_cmt_id),
        .i_haz_br_mask         (i_haz1_br_mask),
        .i_haz_haz_typ         (i_haz1_haz_typ),
        .i_haz_haz_info        (i_haz1_haz_info),
        .i_missu_full          (i_missu_full),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_oh    (i_missu_resolve_oh),
        .i_missu_entry_valids  (i_missu_entry_valids),
        .i_stq_resolve_valid   (i_stq_resolve_valid),
        .i_stq_resolve_id      (i_stq_resolve_id),
        .i_br_update           (i_br_update),
        .i_br_tag              (i_br_tag),
        .i_br_mispredict       (i_br_mispredict),
        .o_req_valid           (w_req1_valid),
        .o_req_paddr           (w_req1_paddr),
        .o_req_cmt_id          (w_req1_cmt_id),
        .o_req_br_mask         (w_req1_br_mask),
        .o_req_haz_typ         (w_req1_haz_typ),
        .o_req_haz_info        (),
        .i_req_ready           (w_req1_ready),
        .o_credit              (o_credit1)
    );

    lsu_replay_arbiter u_arbiter (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_req0_valid   (w_req0_valid),
        .i_req0_paddr   (w_req0_paddr),
        .i_req0_cmt_id  (w_req0_cmt_id),
        .i_req0_haz_typ (w_req0_haz_typ),
        .i_req0_br_mask (w_req0_br_mask),
        .o_req0_ready   (w_req0_ready),
        .i_req1_valid   (w_req1_valid),
        .i_req1_paddr   (w_req1_paddr),
        .i_req1_cmt_id  (w_req1_cmt_id),
        .i_req1_haz_typ (w_req1_haz_typ),
        .i_req1_br_mask (w_req1_br_mask),
        .o_req1_ready   (w_req1_ready),
        .o_rep_valid    (o_rep_valid),
        .o_rep_pipe     (o_rep_pipe),
        .o_rep_paddr    (o_rep_paddr),
        .o_rep_cmt_id   (o_rep_cmt_id),
        .o_rep_haz_typ  (o_rep_haz_typ),
        .o_rep_br_mask  (o_rep_br_mask),
        .i_rep_ready    (i_rep_ready)
    );

endmodule

// ==== dv/lsu_replay_tests.svh ====
// Stimulus helpers and directed tests for the LSU replay subsystem

`ifndef LSU_REPLAY_TESTS_SVH
`define LSU_REPLAY_TESTS_SVH

function automatic rep_t new_entry(input logic pipe, input haz_typ_t typ,
                                   input logic [BR_MASK_W-1:0] br_mask);
    rep_t r;
    r.pipe      = pipe;
    r.paddr     = PADDR_W'($urandom());
    r.cmt_id    = next_cmt_id;
    r.typ       = typ;
    r.br_mask   = br_mask;
    next_cmt_id = next_cmt_id + CMT_ID_W'(1);
    return r;
endfunction

task automatic drive_hazard(input rep_t r, input haz_info_u info);
    if (r.pipe) begin
        i_haz1_valid    <= 1'b1;
        i_haz1_paddr    <= r.paddr;
        i_haz1_cmt_id   <= r.cmt_id;
        i_haz1_br_mask  <= r.br_mask;
        i_haz1_haz_typ  <= r.typ;
        i_haz1_haz_info <= info;
    end else begin
        i_haz0_valid    <= 1'b1;
        i_haz0_paddr    <= r.paddr;
        i_haz0_cmt_id   <= r.cmt_id;
        i_haz0_br_mask  <= r.br_mask;
        i_haz0_haz_typ  <= r.typ;
        i_haz0_haz_info <= info;
    end
endtask

task automatic await_credit(input logic pipe);
    int n = 0;
    while (credits[pipe] == 0) begin
        @(posedge i_clk);
        n++;
        if (n > WAIT_LIMIT) stop_run($sformatf("timeout waiting for a pipe %0d credit", pipe));
    end
endtask

// Held for one cycle, pushed at the following edge
task automatic send_hazard(input rep_t r, input haz_info_u info, input bit expected);
    await_credit(r.pipe);
    if (expected) exp_q.push_back(r);
    @(posedge i_clk);
    drive_hazard(r, info);
    @(posedge i_clk);
    i_haz0_valid <= 1'b0;
    i_haz1_valid <= 1'b0;
endtask

task automatic send_pair(input rep_t r0, input rep_t r1, input bit expected);
    await_credit(1'b0);
    await_credit(1'b1);
    if (expected) begin
        exp_q.push_back(r0);
        exp_q.push_back(r1);
    end
    @(posedge i_clk);
    drive_hazard(r0, '0);
    drive_hazard(r1, '0);
    @(posedge i_clk);
    i_haz0_valid <= 1'b0;
    i_haz1_valid <= 1'b0;
endtask

task automatic wait_drained;
    int n = 0;
    while (n_seen != exp_q.size()) begin
        @(posedge i_clk);
        n++;
        if (n > WAIT_LIMIT) stop_run("timeout waiting for the expected replays");
    end
endtask

task automatic wait_credits_full;
    int n = 0;
    while (credits[0] != QUEUE_DEPTH || credits[1] != QUEUE_DEPTH) begin
        @(posedge i_clk);
        n++;
        if (n > WAIT_LIMIT) stop_run("timeout waiting for all credits to return");
    end
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic l1d_conflict_order;
    rep_t r0;
    rep_t r1;
    for (int i = 0; i < 3; i++) begin
        r0 = new_entry(1'b0, HAZ_L1D_CONFLICT, 4'b0000);
        r1 = new_entry(1'b1, HAZ_L1D_CONFLICT, 4'b0000);
        send_pair(r0, r1, 1'b1);    // Both heads ready together, pipe 0 first
    end
    wait_drained();
    wait_credits_full();
endtask

task automatic missu_full_block;
    rep_t r_full;
    rep_t r_next;
    i_missu_full <= 1'b1;
    r_full = new_entry(1'b0, HAZ_MISSU_FULL, 4'b0000);
    r_next = new_entry(1'b0, HAZ_L1D_CONFLICT, 4'b0000);
    send_hazard(r_full, '0, 1'b0);
    send_hazard(r_next, '0, 1'b0);  // Blocked behind the head
    repeat (10) @(posedge i_clk);
    exp_q.push_back(r_full);
    exp_q.push_back(r_next);
    i_missu_full <= 1'b0;
    wait_drained();
    wait_credits_full();
endtask

task automatic missu_assigned_wakeup;
    rep_t      r_a;
    rep_t      r_b;
    haz_info_u info_a;
    haz_info_u info_b;
    info_a.missu_index_oh = 8'h04;
    info_b.missu_index_oh = 8'h10;
    r_a = new_entry(1'b1, HAZ_MISSU_ASSIGNED, 4'b0000);
    r_b = new_entry(1'b0, HAZ_MISSU_ASSIGNED, 4'b0000);
    send_hazard(r_a, info_a, 1'b0);
    send_hazard(r_b, info_b, 1'b0);
    i_missu_resolve_valid <= 1'b1;
    i_missu_resolve_oh    <= 8'h08;     // Some other entry
    @(posedge i_clk);
    i_missu_resolve_valid <= 1'b0;
    repeat (5) @(posedge i_clk);
    exp_q.push_back(r_a);
    i_missu_resolve_valid <= 1'b1;
    i_missu_resolve_oh    <= 8'h04;
    @(posedge i_clk);
    i_missu_resolve_valid <= 1'b0;
    wait_drained();
    exp_q.push_back(r_b);
    i_missu_entry_valids <= 8'hef;      // Entry 4 freed
    wait_drained();
    i_missu_entry_valids <= 8'hff;
    wait_credits_full();
endtask

task automatic stq_nonfwd_wakeup;
    rep_t      r_s;
    haz_info_u info_s;
    info_s.stq_id = 8'd5;
    r_s = new_entry(1'b0, HAZ_STQ_NONFWD, 4'b0000);
    send_hazard(r_s, info_s, 1'b0);
    i_stq_resolve_valid <= 1'b1;
    i_stq_resolve_id    <= 8'd3;
    @(posedge i_clk);
    i_stq_resolve_valid <= 1'b0;
    repeat (5) @(posedge i_clk);
    exp_q.push_back(r_s);
    i_stq_resolve_valid <= 1'b1;
    i_stq_resolve_id    <= 8'd5;
    @(posedge i_clk);
    i_stq_resolve_valid <= 1'b0;
    wait_drained();
    wait_credits_full();
endtask

task automatic branch_flush_drain;
    rep_t r_dead0;
    rep_t r_live;
    rep_t r_dead1;
    i_missu_full <= 1'b1;               // Holds all three in place
    r_dead0 = new_entry(1'b0, HAZ_MISSU_FULL, 4'b0010);
    r_live  = new_entry(1'b0, HAZ_MISSU_FULL, 4'b0001);
    r_dead1 = new_entry(1'b1, HAZ_MISSU_FULL, 4'b0110);
    send_hazard(r_dead0, '0, 1'b0);
    send_hazard(r_live, '0, 1'b0);
    send_hazard(r_dead1, '0, 1'b0);
    // Correct prediction first, nothing dies
    i_br_update     <= 1'b1;
    i_br_tag        <= 4'b0011;
    i_br_mispredict <= 1'b0;
    @(posedge i_clk);
    i_br_tag        <= 4'b0010;
    i_br_mispredict <= 1'b1;
    @(posedge i_clk);
    i_br_update     <= 1'b0;
    i_br_mispredict <= 1'b0;
    exp_q.push_back(r_live);
    i_missu_full <= 1'b0;
    wait_drained();
    wait_credits_full();                // Dead entries return credits too
endtask

task automatic backpressure_credits;
    rep_t pipe0_set [QUEUE_DEPTH];
    rep_t pipe1_set [QUEUE_DEPTH];
    logic first;
    i_rep_ready <= 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        pipe0_set[i] = new_entry(1'b0, HAZ_L1D_CONFLICT, 4'b0000);
        pipe1_set[i] = new_entry(1'b1, HAZ_L1D_CONFLICT, 4'b0000);
        send_pair(pipe0_set[i], pipe1_set[i], 1'b0);
    end
    repeat (5) @(posedge i_clk);
    check_count("pipe 0 credits", credits[0], 0);
    check_count("pipe 1 credits", credits[1], 0);
    // Pointer sits on the side not served last, then alternates
    first = ~last_pipe;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        exp_q.push_back(first ? pipe1_set[i] : pipe0_set[i]);
        exp_q.push_back(first ? pipe0_set[i] : pipe1_set[i]);
    end
    i_rep_ready <= 1'b1;
    wait_drained();
    wait_credits_full();
endtask

`endif

// ==== dv/lsu_replay_tb.sv ====
// LSU replay testbench top
// Clock, reset, DUT, replay and credit monitor, compare tasks

`timescale 1ns/10ps

module lsu_replay_tb;
    import lsu_replay_pkg::*;

    localparam int          QUEUE_DEPTH = 4;
    localparam int          WAIT_LIMIT  = 200;
    localparam logic [31:0] SEED        = 32'hc137_3dfb;

    typedef struct packed {
        logic                 pipe;
        logic [PADDR_W-1:0]   paddr;
        logic [CMT_ID_W-1:0]  cmt_id;
        haz_typ_t             typ;
        logic [BR_MASK_W-1:0] br_mask;
    } rep_t;

    logic                     i_clk;
    logic                     i_reset_n;
    logic                     i_haz0_valid;
    logic [PADDR_W-1:0]       i_haz0_paddr;
    logic [CMT_ID_W-1:0]      i_haz0_cmt_id;
    logic [BR_MASK_W-1:0]     i_haz0_br_mask;
    haz_typ_t                 i_haz0_haz_typ;
    haz_info_u                i_haz0_haz_info;
    logic                     i_haz1_valid;
    logic [PADDR_W-1:0]       i_haz1_paddr;
    logic [CMT_ID_W-1:0]      i_haz1_cmt_id;
    logic [BR_MASK_W-1:0]     i_haz1_br_mask;
    haz_typ_t                 i_haz1_haz_typ;
    haz_info_u                i_haz1_haz_info;
    logic                     i_missu_full;
    logic                     i_missu_resolve_valid;
    logic [MISSU_ENTRIES-1:0] i_missu_resolve_oh;
    logic [MISSU_ENTRIES-1:0] i_missu_entry_valids;
    logic                     i_stq_resolve_valid;
    logic [MISSU_ENTRIES-1:0] i_stq_resolve_id;
    logic                     i_br_update;
    logic [BR_MASK_W-1:0]     i_br_tag;
    logic                     i_br_mispredict;
    logic                     o_credit0;
    logic                     o_credit1;
    logic                     o_rep_valid;
    logic                     o_rep_pipe;
    logic [PADDR_W-1:0]       o_rep_paddr;
    logic [CMT_ID_W-1:0]      o_rep_cmt_id;
    haz_typ_t                 o_rep_haz_typ;
    logic [BR_MASK_W-1:0]     o_rep_br_mask;
    logic                     i_rep_ready;

    rep_t                exp_q [$];    // Replays in expected issue order
    rep_t                want;
    int                  n_seen;
    int                  credits [2];
    logic                last_pipe;
    logic [CMT_ID_W-1:0] next_cmt_id;

    lsu_replay_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // ------------------------------
    // Error reporting and compares
    // ------------------------------
    task automatic end_in_failure;
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic stop_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        end_in_failure();
    endtask

    task automatic check_typ(input string name, input haz_typ_t got, input haz_typ_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
            end_in_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [PADDR_W-1:0] got,
                              input logic [PADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_pipe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            end_in_failure();
        end
    endtask

    // ------------------------------
    // Monitor sampled mid-cycle
    // ------------------------------
    always @(negedge i_clk) begin
        if (!i_reset_n) begin
            n_seen     = 0;
            credits[0] = QUEUE_DEPTH;
            credits[1] = QUEUE_DEPTH;
            last_pipe  = 1'b1;          // Arbiter favours pipe 0 after reset
        end else begin
            if (o_rep_valid && i_rep_ready) begin
                if (n_seen >= exp_q.size()) begin
                    stop_run($sformatf("unexpected replay of address %h from pipe %0d",
                                       o_rep_paddr, o_rep_pipe));
                end else begin
                    want = exp_q[n_seen];
                    check_pipe("o_rep_pipe", o_rep_pipe, want.pipe);
                    check_word("o_rep_paddr", o_rep_paddr, want.paddr);
                    check_word("o_rep_cmt_id", PADDR_W'(o_rep_cmt_id), PADDR_W'(want.cmt_id));
                    check_typ("o_rep_haz_typ", o_rep_haz_typ, want.typ);
                    check_word("o_rep_br_mask", PADDR_W'(o_rep_br_mask),
                               PADDR_W'(want.br_mask));
                    last_pipe = want.pipe;
                    n_seen++;
                end
            end
            credits[0] = credits[0] + int'(o_credit0) - int'(i_haz0_valid);
            credits[1] = credits[1] + int'(o_credit1) - int'(i_haz1_valid);
            if (credits[0] < 0 || credits[1] < 0) begin
                stop_run("a pipe sent a hazard without holding a credit");
            end else if (credits[0] > QUEUE_DEPTH || credits[1] > QUEUE_DEPTH) begin
                stop_run("more credits came back than entries were sent");
            end
        end
    end

    `include "lsu_replay_tests.svh"

    initial begin
        void'($urandom(SEED));
        next_cmt_id = '0;
        i_reset_n             <= 1'b0;
        i_haz0_valid          <= 1'b0;
        i_haz0_paddr          <= '0;
        i_haz0_cmt_id         <= '0;
        i_haz0_br_mask        <= '0;
        i_haz0_haz_typ        <= HAZ_L1D_CONFLICT;
        i_haz0_haz_info       <= '0;
        i_haz1_valid          <= 1'b0;
        i_haz1_paddr          <= '0;
        i_haz1_cmt_id         <= '0;
        i_haz1_br_mask        <= '0;
        i_haz1_haz_typ        <= HAZ_L1D_CONFLICT;
        i_haz1_haz_info       <= '0;
        i_missu_full          <= 1'b0;
        i_missu_resolve_valid <= 1'b0;
        i_missu_resolve_oh    <= '0;
        i_missu_entry_valids  <= '1;    // All miss-unit entries busy
        i_stq_resolve_valid   <= 1'b0;
        i_stq_resolve_id      <= '0;
        i_br_update           <= 1'b0;
        i_br_tag              <= '0;
        i_br_mispredict       <= 1'b0;
        i_rep_ready           <= 1'b1;
        repeat (8) @(posedge i_clk);
        i_reset_n <= 1'b1;
        repeat (2) @(posedge i_clk);
        l1d_conflict_order();
        missu_full_block();
        missu_assigned_wakeup();
        stq_nonfwd_wakeup();
        branch_flush_drain();
        backpressure_credits();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== lsu_replay.f ====
+incdir+dv
source/lsu_replay_pkg.sv
source/ring_fifo.sv
source/lsu_replay_queue.sv
source/lsu_replay_arbiter.sv
source/lsu_replay_top.sv
dv/lsu_replay_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LSU replay testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f lsu_replay.f --top-module lsu_replay_tb \
    -Mdir "$BUILD_DIR" -o lsu_replay_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/lsu_replay_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
